// ==== design/hr_16t4_mux.sv ====
`timescale 1ns/10ps

module hr_16t4_mux (
    input  logic                mdll_clk,
    input  logic                arst_n,
    tx_lane_intf.hr             lane,
    input  tx_type_pack::word_t word_in          // Data buffer head
);

    import tx_const_pack::*;
    import tx_type_pack::*;

    word_t word_q;                               // Word of the current slot
    nib_t  nib_q;                                // Registered nibble
    nib_t  nib_sel;

    // Nibble n holds bits 4n to 4n+3, LSB first on the line
    assign nib_sel = word_q[lane.nib_idx*nib_w +: nib_w];

    always_ff @(posedge mdll_clk) begin
        if (lane.adv && lane.load_word) begin
            word_q <= word_in;                   // Captured as the slot starts
        end
    end

    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            nib_q <= '0;
        end else if (lane.adv) begin
            if (lane.run) nib_q <= nib_sel;      // One cycle behind the position
            else nib_q <= '0;                    // Idle and drain send zeros
        end
    end

    assign lane.nibble = nib_q;

endmodule

// ==== design/qr_4t1_mux.sv ====
`timescale 1ns/10ps

module qr_4t1_mux (
    input  logic     mdll_clk,
    input  logic     arst_n,
    tx_lane_intf.qr  lane,
    output logic     dout_p,
    output logic     dout_n
);

    import tx_const_pack::*;

    logic [bit_sel_w-1:0] bit_idx_q;             // Aligned to the registered nibble
    logic                 run_q;
    logic                 cur;                   // Bit leaving the serializer
    logic [max_phase-1:0] dly_q;                 // dly_q[j] is cur late by j+1
    logic [max_phase:0]   taps;
    logic                 dout_p_q;
    logic                 dout_n_q;

    assign cur  = run_q && lane.nibble[bit_idx_q];
    assign taps = {dly_q, cur};                  // Tap 0 is undelayed

    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_idx_q <= '0;
            run_q     <= 1'b0;
        end else if (lane.adv) begin
            bit_idx_q <= lane.bit_idx;
            run_q     <= lane.run;
        end
    end

    // Digital stand-in for the phase interpolator
    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            dly_q <= '0;
        end else if (lane.adv) begin
            dly_q <= {dly_q[max_phase-2:0], cur};
        end
    end

    // Output pair, registered
    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            dout_p_q <= 1'b0;
            dout_n_q <= 1'b1;
        end else if (lane.adv) begin
            dout_p_q <= taps[lane.phase];
            dout_n_q <= ~taps[lane.phase];       // Complement leg
        end
    end

    assign dout_p = dout_p_q;
    assign dout_n = dout_n_q;

endmodule

// ==== design/tx_bit_counter.sv ====
`timescale 1ns/10ps

module tx_bit_counter (
    input  logic      mdll_clk,
    input  logic      arst_n,
    tx_lane_intf.cnt  lane,
    output logic      clk_prbsgen                // Word-slot marker for the pattern source
);

    import tx_const_pack::*;

    logic [pos_w-1:0]   pos_q;                   // Bit position in the slot
    logic [drain_w-1:0] drain_q;                 // Idle cycles still to wait

    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            pos_q <= '0;
        end else if (lane.adv) begin
            if (lane.load_word) pos_q <= '0;     // New slot starts at bit 0
            else if (lane.run) pos_q <= pos_q + pos_w'(1);
        end
    end

    // Held at full count while running, counts down once run falls
    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            drain_q <= '0;
        end else if (lane.adv) begin
            if (lane.run) drain_q <= drain_w'(drain_cycles);
            else if (drain_q != '0) drain_q <= drain_q - drain_w'(1);
        end
    end

    // Upper bits pick the nibble, lower bits the bit inside it
    assign lane.nib_idx   = pos_q[pos_w-1 -: nib_sel_w];
    assign lane.bit_idx   = pos_q[bit_sel_w-1:0];
    assign lane.slot_last = lane.run && (pos_q == pos_w'(word_w - 1));
    assign lane.drained   = (drain_q == '0);

    // High on bits 0 to 7 of a running slot
    assign clk_prbsgen = lane.run && (pos_q < pos_w'(half_slot));

endmodule

// ==== design/tx_const_pack.sv ====
package tx_const_pack;

    // Word and nibble geometry
    localparam int word_w = 16;                  // Bits per data word
    localparam int nib_w  = 4;                   // Bits per nibble
    localparam int n_nib  = 4;                   // Nibbles per word

    // Phase control
    localparam int npi       = 3;                // Phase code width
    localparam int max_phase = 7;                // Deepest delay in bit periods

    // Idle cycles after the last slot before a new code may be taken.
    // Long enough for the deepest tap to flush
    localparam int drain_cycles = 9;

    // Cycles from word acceptance in idle to bit 0 at phase 0
    localparam int first_bit_lat = 3;

    // Derived widths
    localparam int pos_w     = $clog2(word_w);   // Slot bit position
    localparam int nib_sel_w = $clog2(n_nib);    // Nibble select
    localparam int bit_sel_w = $clog2(nib_w);    // Bit select inside nibble
    localparam int drain_w   = $clog2(drain_cycles + 1);

    // clk_prbsgen high for the first half of a slot
    localparam int half_slot = word_w / 2;

endpackage

// ==== design/tx_lane_intf.sv ====
`timescale 1ns/10ps

interface tx_lane_intf (
    input logic adv                              // Clock enable, cke
);

    import tx_const_pack::*;
    import tx_type_pack::*;

    // From the slot FSM
    logic                 load_word;             // One-cycle load strobe
    logic                 run;                   // Slot in progress
    pi_code_t             phase;                 // Applied phase code

    // From the bit counter
    logic [nib_sel_w-1:0] nib_idx;               // Current nibble
    logic [bit_sel_w-1:0] bit_idx;               // Bit inside the nibble
    logic                 slot_last;             // Bit 15 of the slot
    logic                 drained;               // Drain timer expired

    // From the half-rate mux
    nib_t                 nibble;

    modport ctrl (
        input  adv, slot_last, drained,
        output load_word, run, phase
    );

    modport cnt (
        input  adv, load_word, run,
        output nib_idx, bit_idx, slot_last, drained
    );

    modport hr (
        input  adv, load_word, run, nib_idx,
        output nibble
    );

    modport qr (
        input  adv, nibble, bit_idx, run, phase
    );

endinterface

// ==== design/tx_skid_buf.sv ====
`timescale 1ns/10ps

module tx_skid_buf #(
    parameter type payload_t = logic
) (
    input  logic     mdll_clk,
    input  logic     arst_n,
    input  logic     adv,                        // Freezes the buffer when low
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t   mem [2];                         // Two storage entries
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;                           // 0, 1 or 2 entries held
    logic [1:0] count_d;
    logic       rdy_q;                           // Registered free flag
    logic       push;
    logic       pop;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready && adv;

    always_comb begin
        count_d = count;
        if (push && !pop) count_d = count + 2'd1;
        else if (pop && !push) count_d = count - 2'd1;
    end

    // Ready comes from a register, not from out_ready
    assign in_ready  = rdy_q && adv;
    assign out_valid = (count != 2'd0);
    assign out_data  = mem[rd_ptr];              // Head entry

    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
            rdy_q  <= 1'b0;                      // Rises on the first enabled edge
        end else if (adv) begin
            if (push) wr_ptr <= ~wr_ptr;
            if (pop) rd_ptr <= ~rd_ptr;
            count <= count_d;
            rdy_q <= (count_d != 2'd2);          // Room left after this edge
        end
    end

    always_ff @(posedge mdll_clk) begin
        if (push) mem[wr_ptr] <= in_data;        // Storage only
    end

endmodule

// ==== design/tx_slot_fsm.sv ====
`timescale 1ns/10ps

module tx_slot_fsm (
    input  logic                   mdll_clk,
    input  logic                   arst_n,
    tx_lane_intf.ctrl              lane,
    input  logic                   word_valid,  // Data buffer head valid
    output logic                   word_take,   // Pop the data buffer
    input  tx_type_pack::pi_code_t code_in,     // Phase buffer head
    input  logic                   code_valid,
    output logic                   code_take,   // Pop the phase buffer
    output logic                   code_open    // Idle and enabled
);

    import tx_type_pack::*;

    slot_state_t state_q;
    slot_state_t state_d;
    pi_code_t    phase_q;                        // Applied delay
    pi_code_t    phase_d;
    logic        load;

    always_comb begin
        state_d   = state_q;
        phase_d   = phase_q;
        load      = 1'b0;
        code_take = 1'b0;
        case (state_q)
            st_idle: begin
                // A pending code goes first so it covers the next word
                if (code_valid) begin
                    code_take = 1'b1;
                    phase_d   = code_in;
                end else if (word_valid) begin
                    load    = 1'b1;
                    state_d = st_run;
                end
            end
            st_run: begin
                if (lane.slot_last) begin
                    if (word_valid) load = 1'b1;    // Seamless next slot
                    else state_d = st_drain;
                end
            end
            st_drain: begin
                if (word_valid) begin
                    load    = 1'b1;                 // Restart without waiting
                    state_d = st_run;
                end else if (lane.drained) begin
                    state_d = st_idle;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    assign lane.load_word = load;
    assign lane.run       = (state_q == st_run);
    assign lane.phase     = phase_q;
    assign word_take      = load;
    assign code_open      = lane.adv && (state_q == st_idle); // Gates ctl_ready

    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
            phase_q <= '0;                       // Phase 0 out of reset
        end else if (lane.adv) begin
            state_q <= state_d;
            phase_q <= phase_d;
        end
    end

endmodule

// ==== design/tx_top.sv ====
`timescale 1ns/10ps

module tx_top (
    input  logic                            mdll_clk,    // Bit clock
    input  logic                            arst_n,
    input  logic                            cke,         // Lane clock enable
    input  logic [tx_const_pack::word_w-1:0] din,        // Parallel word
    input  logic                            din_valid,
    output logic                            din_ready,
    input  logic [tx_const_pack::npi-1:0]   ctl_pi,      // Phase code
    input  logic                            ctl_valid,
    output logic                            ctl_ready,
    output logic                            dout_p,      // Serial data, true
    output logic                            dout_n,      // Serial data, complement
    output logic                            clk_prbsgen  // Slot marker
);

    import tx_type_pack::*;

    word_t    word_head;                         // Data buffer head
    logic     word_valid;
    logic     word_take;
    pi_code_t code_head;                         // Phase buffer head
    logic     code_valid;
    logic     code_take;
    logic     code_open;                         // Idle state, also phase buffer enable

    tx_lane_intf lane (.adv(cke));

    // Data words
    tx_skid_buf #(.payload_t(word_t)) data_buf (
        .mdll_clk  (mdll_clk),
        .arst_n    (arst_n),
        .adv       (cke),
        .in_data   (din),
        .in_valid  (din_valid),
        .in_ready  (din_ready),
        .out_data  (word_head),
        .out_valid (word_valid),
        .out_ready (word_take)
    );

    // Phase codes, only open while idle
    tx_skid_buf #(.payload_t(pi_code_t)) code_buf (
        .mdll_clk  (mdll_clk),
        .arst_n    (arst_n),
        .adv       (code_open),
        .in_data   (ctl_pi),
        .in_valid  (ctl_valid),
        .in_ready  (ctl_ready),
        .out_data  (code_head),
        .out_valid (code_valid),
        .out_ready (code_take)
    );

    tx_slot_fsm slot_fsm (
        .mdll_clk   (mdll_clk),
        .arst_n     (arst_n),
        .lane       (lane.ctrl),
        .word_valid (word_valid),
        .word_take  (word_take),
        .code_in    (code_head),
        .code_valid (code_valid),
        .code_take  (code_take),
        .code_open  (code_open)
    );

    tx_bit_counter bit_cnt (
        .mdll_clk    (mdll_clk),
        .arst_n      (arst_n),
        .lane        (lane.cnt),
        .clk_prbsgen (clk_prbsgen)
    );

    // Half-rate 16 to 4 mux
    hr_16t4_mux hr_mux_16t4 (
        .mdll_clk (mdll_clk),
        .arst_n   (arst_n),
        .lane     (lane.hr),
        .word_in  (word_head)
    );

    // Quarter-rate 4 to 1 mux and output pair
    qr_4t1_mux qr_mux_4t1 (
        .mdll_clk (mdll_clk),
        .arst_n   (arst_n),
        .lane     (lane.qr),
        .dout_p   (dout_p),
        .dout_n   (dout_n)
    );

endmodule

// ==== design/tx_type_pack.sv ====
package tx_type_pack;

    import tx_const_pack::*;

    // One parallel data word, bit 0 leaves first
    typedef logic [word_w-1:0] word_t;

    // Quarter-rate slice of a word
    typedef logic [nib_w-1:0] nib_t;

    // Delay in whole bit periods, 0 to max_phase
    typedef logic [npi-1:0] pi_code_t;

    // Slot controller states
    typedef enum logic [1:0] {
        st_idle,                                 // Nothing in flight, codes accepted
        st_run,                                  // Slot in progress
        st_drain                                 // Waiting for the delay line to empty
    } slot_state_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build and run the lane transmitter testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --top-module tx_tb -f tb.f -o tx_sim > build.log 2>&1 \
    && ./obj_dir/tx_sim > sim.log 2>&1 \
    || { cat build.log; echo "Build or run failed"; }

cat sim.log 2>/dev/null
grep -q "^PASS: all tests$" sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }

// ==== tb.f ====
design/tx_const_pack.sv
design/tx_type_pack.sv
design/tx_lane_intf.sv
design/tx_skid_buf.sv
design/tx_slot_fsm.sv
design/tx_bit_counter.sv
design/hr_16t4_mux.sv
design/qr_4t1_mux.sv
design/tx_top.sv
verif/tx_checker.sv
verif/tx_tb.sv

// ==== verif/tx_checker.sv ====
`timescale 1ns/10ps

module tx_checker (
    input  logic                             mdll_clk,
    input  logic                             arst_n,
    input  logic                             cke,
    input  logic [tx_const_pack::word_w-1:0] din,
    input  logic                             din_valid,
    input  logic                             din_ready,
    input  logic [tx_const_pack::npi-1:0]    ctl_pi,
    input  logic                             ctl_valid,
    input  logic                             ctl_ready,
    input  logic                             dout_p,
    input  logic                             dout_n,
    input  logic                             clk_prbsgen,
    output int                               errors,      // Mismatches so far
    output logic                             model_idle   // Nothing queued or in flight
);

    import tx_const_pack::*;
    import tx_type_pack::*;

    slot_state_t        m_state;
    logic [pos_w-1:0]   m_pos;                   // Slot bit position
    int                 m_drain;                 // Idle cycles still to wait
    pi_code_t           m_phase;
    word_t              m_word;                  // Word of the running slot
    logic [max_phase:0] m_hist;                  // Serial bit history, newest at 0
    word_t              m_wq[$];                 // Accepted words not yet loaded
    pi_code_t           m_cq[$];                 // Accepted codes not yet applied
    logic               m_word_rdy;
    logic               m_code_rdy;
    logic               exp_p;
    logic               exp_prbs;

    // Steps the slot rules by one enabled edge, returns dout_p after that edge
    function logic expected_bit(input logic acc_w, input word_t w,
                                input logic acc_c, input pi_code_t c);
        logic        s;
        logic        load;
        logic        take;
        logic        nxt;
        slot_state_t nst;
        s    = (m_state == st_run) ? m_word[m_pos] : 1'b0;
        nxt  = m_hist[m_phase];                  // Delay picked by the applied code
        load = 1'b0;
        take = 1'b0;
        nst  = m_state;
        case (m_state)
            st_idle: begin
                if (m_cq.size() != 0) take = 1'b1;   // Code before word
                else if (m_wq.size() != 0) begin
                    load = 1'b1;
                    nst  = st_run;
                end
            end
            st_run: begin
                if (m_pos == pos_w'(word_w - 1)) begin
                    if (m_wq.size() != 0) load = 1'b1;
                    else nst = st_drain;
                end
            end
            default: begin
                if (m_wq.size() != 0) begin
                    load = 1'b1;
                    nst  = st_run;
                end else if (m_drain == 0) nst = st_idle;
            end
        endcase
        m_hist = {m_hist[max_phase-1:0], s};
        if (load) m_word = m_wq.pop_front();
        if (load) m_pos = '0;
        else if (m_state == st_run) m_pos = m_pos + 4'd1;
        if (m_state == st_run) m_drain = drain_cycles;
        else if (m_drain != 0) m_drain = m_drain - 1;
        if (take) m_phase = m_cq.pop_front();
        if (acc_c) m_cq.push_back(c);
        if (m_state == st_idle) m_code_rdy = (m_cq.size() != 2);  // Code buffer only runs in idle
        if (acc_w) m_wq.push_back(w);
        m_word_rdy = (m_wq.size() != 2);
        m_state    = nst;
        return nxt;
    endfunction

    task report(input string name, input logic e, input logic a);
        if (e !== a) begin
            errors = errors + 1;
            $display("[ERROR] t=%0t %s expected %0b actual %0b", $time, name, e, a);
        end
    endtask

    // Compare values settled before the edge, then advance the model
    always @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            m_state    = st_idle;
            m_pos      = '0;
            m_drain    = 0;
            m_phase    = '0;
            m_word     = '0;
            m_hist     = '0;
            m_wq.delete();
            m_cq.delete();
            m_word_rdy = 1'b0;
            m_code_rdy = 1'b0;
            exp_p      = 1'b0;
            exp_prbs   = 1'b0;
            model_idle = 1'b1;
            errors     = 0;
        end else begin
            report("dout_p", exp_p, dout_p);
            report("dout_n", ~exp_p, dout_n);
            report("clk_prbsgen", exp_prbs, clk_prbsgen);
            report("din_ready", cke && m_word_rdy, din_ready);
            report("ctl_ready", cke && (m_state == st_idle) && m_code_rdy, ctl_ready);
            if (cke) begin
                exp_p = expected_bit(din_valid && din_ready, din, ctl_valid && ctl_ready, ctl_pi);
                exp_prbs   = (m_state == st_run) && (m_pos < pos_w'(half_slot));
                model_idle = (m_state == st_idle) && (m_wq.size() == 0)
                             && (m_cq.size() == 0) && (m_hist == '0);
            end
        end
    end

endmodule

// ==== verif/tx_tb.sv ====
`timescale 1ns/10ps

module tx_tb;

    import tx_const_pack::*;

    logic        mdll_clk;
    logic        arst_n;
    logic        cke;
    logic [15:0] din;
    logic        din_valid;
    logic        din_ready;
    logic [2:0]  ctl_pi;
    logic        ctl_valid;
    logic        ctl_ready;
    logic        dout_p;
    logic        dout_n;
    logic        clk_prbsgen;
    int          errors;                         // From the checker
    logic        model_idle;
    logic        jitter;                         // Random cke low periods when set
    logic        test_bad;
    int          err_mark;
    int          n_tests;
    int          n_failed;
    int          stalls;

    tx_top UUT (.*);

    tx_checker chk (.*);

    initial begin
        mdll_clk = 1'b0;
        forever #10 mdll_clk = ~mdll_clk;
    end

    always @(negedge mdll_clk) begin
        if (jitter) cke = ($urandom_range(0, 3) != 0);
    end

    task start_test();
        err_mark = errors;
        test_bad = 1'b0;
    endtask

    task end_test(input string name);
        n_tests = n_tests + 1;
        if (test_bad || errors != err_mark) begin
            n_failed = n_failed + 1;
            $display("test %s: failed", name);
        end else $display("test %s: passed", name);
    endtask

    task send_word(input logic [15:0] w);
        int n;
        logic acc;
        n   = 0;
        acc = 1'b0;
        @(negedge mdll_clk);
        din       = w;
        din_valid = 1'b1;
        do begin
            @(posedge mdll_clk);
            acc = din_ready;                     // Transfer on this edge
            n   = n + 1;
        end while (!acc && n < 200);
        if (!acc) begin
            $display("Timeout: word was never accepted");
            test_bad = 1'b1;
        end
        @(negedge mdll_clk);
        din_valid = 1'b0;
    endtask

    task send_code(input int p);
        int n;
        logic acc;
        n   = 0;
        acc = 1'b0;
        @(negedge mdll_clk);
        ctl_pi    = 3'(p);
        ctl_valid = 1'b1;
        do begin
            @(posedge mdll_clk);
            acc = ctl_ready;
            n   = n + 1;
        end while (!acc && n < 100);
        if (!acc) begin
            $display("Timeout: phase code was never accepted");
            test_bad = 1'b1;
        end
        @(negedge mdll_clk);
        ctl_valid = 1'b0;
    endtask

    // Valid stays high through the burst, a new word only after a transfer
    task send_burst(input int count);
        int sent;
        int waited;
        logic acc;
        sent   = 0;
        waited = 0;
        stalls = 0;
        @(negedge mdll_clk);
        din       = 16'($urandom);
        din_valid = 1'b1;
        while (sent < count && waited < 100) begin
            @(posedge mdll_clk);
            acc = din_ready;
            if (acc) sent = sent + 1;
            else stalls = stalls + 1;
            waited = acc ? 0 : waited + 1;
            @(negedge mdll_clk);
            if (acc) din = 16'($urandom);
        end
        din_valid = 1'b0;
        if (sent < count) begin
            $display("Timeout: burst stalled with %0d of %0d words sent", sent, count);
            test_bad = 1'b1;
        end
    endtask

    // Counts edges from the accepting edge until the first 1 on dout_p
    task measure_latency(input int lat);
        int k;
        k = 0;
        do begin
            @(posedge mdll_clk);
            k = k + 1;
            @(negedge mdll_clk);
        end while (!dout_p && k < 40);
        if (!dout_p) begin
            $display("Word start never appeared on dout_p");
            test_bad = 1'b1;
        end else if (k != lat) begin
            $display("Word start came %0d cycles after acceptance instead of %0d", k, lat);
            test_bad = 1'b1;
        end
    endtask

    task wait_quiet();
        int n;
        n = 0;
        do begin
            @(negedge mdll_clk);
            n = n + 1;
        end while (!model_idle && n < 400);
        if (!model_idle) begin
            $display("Timeout: lane never returned to idle");
            test_bad = 1'b1;
        end
    endtask

    initial begin
        din       = 16'($urandom(32'hf2b4_75f7));  // Seeds the generator, din unused while idle
        arst_n    = 1'b0;
        cke       = 1'b1;
        din_valid = 1'b0;
        ctl_pi    = '0;
        ctl_valid = 1'b0;
        jitter    = 1'b0;
        n_tests   = 0;
        n_failed  = 0;
        repeat (8) @(posedge mdll_clk);
        @(negedge mdll_clk);
        arst_n = 1'b1;

        start_test();
        wait_quiet();
        repeat (2) @(negedge mdll_clk);
        if (!din_ready || !ctl_ready || dout_p || !dout_n || clk_prbsgen) begin
            $display("Idle state after reset is wrong");
            test_bad = 1'b1;
        end
        end_test("reset_idle");

        start_test();
        send_word(16'ha5a5);
        measure_latency(first_bit_lat);          // Phase 0 from reset
        wait_quiet();
        end_test("single_word");

        start_test();
        send_burst(8);
        wait_quiet();
        end_test("back_to_back");

        start_test();
        for (int p = 0; p <= max_phase; p++) begin
            send_code(p);
            repeat (3) @(negedge mdll_clk);
            send_word(16'h8001);
            measure_latency(first_bit_lat + p);
            wait_quiet();
        end
        end_test("phase_sweep");

        start_test();
        jitter = 1'b1;
        for (int i = 0; i < 12; i++) begin
            repeat ($urandom_range(0, 5)) @(negedge mdll_clk);
            send_word(16'($urandom));
        end
        @(negedge mdll_clk);
        jitter = 1'b0;
        cke    = 1'b1;
        wait_quiet();
        end_test("gaps_and_cke");

        start_test();
        send_burst(12);
        if (stalls == 0) begin
            $display("din_ready never fell during the long burst");
            test_bad = 1'b1;
        end
        wait_quiet();
        end_test("back_pressure");

        $display("tests %0d, failed %0d, mismatches %0d", n_tests, n_failed, errors);
        if (n_failed == 0 && errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
